// ==== design/pat_pkg.sv ====
`default_nettype none

package pat_pkg;

	// ========================================================================
	// widths
	// ========================================================================
	localparam int instr_width     = 20;  // full instruction word
	localparam int data_width      = 8;   // accumulator / data memory width
	localparam int imem_addr_width = 10;  // 1024 program words
	localparam int dmem_addr_width = 8;   // 256 data bytes
	localparam int shift_width     = 3;   // shift amount field of i3 ops

	localparam logic [3:0] prefix_code = 4'b1111;  // escape into next opcode space

	typedef logic [instr_width-1:0]     instr_t;
	typedef logic [data_width-1:0]      data_t;
	typedef logic [imem_addr_width-1:0] imem_addr_t;
	typedef logic [dmem_addr_width-1:0] dmem_addr_t;

	// cond always, i8 prefix, i3 prefix, i0 nop
	localparam instr_t nop_word = 20'h00fff;

	// ========================================================================
	// opcode spaces
	// ========================================================================
	typedef enum logic [3:0] {
		op8_or   = 4'h0,
		op8_and  = 4'h1,
		op8_addm = 4'h2,
		op8_subm = 4'h3,
		op8_add  = 4'h4,
		op8_sub  = 4'h5,
		op8_ldi  = 4'h6,
		op8_ldm  = 4'h7,
		op8_bf   = 4'h8,
		op8_bb   = 4'h9,
		op8_stm  = 4'hb,
		op8_orm  = 4'hd,
		op8_andm = 4'he
	} op8_e;

	typedef enum logic [3:0] {
		op3_shl  = 4'h0,
		op3_shlo = 4'h1,
		op3_shr  = 4'h2,
		op3_asr  = 4'h3,
		op3_in   = 4'h5,
		op3_out  = 4'h8
	} op3_e;

	typedef enum logic [3:0] {
		op0_not  = 4'h0,
		op0_test = 4'h2,
		op0_nop  = 4'hf
	} op0_e;

	// code 3 is treated as always too
	typedef enum logic [1:0] {
		cond_always = 2'd0,
		cond_zero   = 2'd1,
		cond_neg    = 2'd2
	} cond_e;

	typedef enum logic [3:0] {
		alu_or,
		alu_and,
		alu_not,
		alu_add,
		alu_sub,
		alu_shl,
		alu_shlo,
		alu_shr,
		alu_asr,
		alu_pass_b
	} alu_op_e;

	// ========================================================================
	// pipeline payloads
	// ========================================================================
	typedef struct packed {
		instr_t     word;   // nop_word while not valid
		imem_addr_t pc;     // address the word came from
		logic       valid;
	} fetch_t;

	typedef struct packed {
		logic       valid;
		cond_e      cond;
		alu_op_e    alu_op;
		data_t      operand_b;      // immediate, shift amount or memory byte
		logic       writes_acc;
		logic       writes_mem;
		dmem_addr_t mem_addr;
		logic       is_branch;
		logic       branch_back;    // bb subtracts the offset
		data_t      branch_offset;  // unsigned
		logic       is_in;
		logic       is_out;
		logic       is_test;
		imem_addr_t pc;
	} decoded_t;

	typedef struct packed {
		logic       taken;
		imem_addr_t target;
	} redirect_t;

endpackage

`default_nettype wire

// ==== design/instruction_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_memory import pat_pkg::*;
(
	input  wire        clk,
	input  logic       i_write,       // level, one word per cycle
	input  imem_addr_t i_write_addr,
	input  instr_t     i_write_data,
	input  imem_addr_t i_read_addr,
	output instr_t     o_read_data    // valid the cycle after the address
);

	instr_t mem [0:(1 << imem_addr_width)-1];  // program store

	always_ff @(posedge clk)
	begin
		if (i_write)
		begin
			mem[i_write_addr] <= i_write_data;  // loader port
		end
		o_read_data <= mem[i_read_addr];  // registered read, one-cycle fetch
	end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import pat_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  redirect_t  i_redirect,
	output imem_addr_t o_read_addr,
	input  instr_t     i_read_data,
	output fetch_t     o_fetch
);

	imem_addr_t pc;          // address presented this cycle
	imem_addr_t fetch_pc;    // address of the word now arriving
	logic       fetch_valid; // arriving word still wanted

	assign o_read_addr = pc;

	// ========================================================================
	// program counter
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc          <= '0;
			fetch_valid <= 1'b0;  // nothing in flight on the first cycle
		end
		else if (i_redirect.taken)
		begin
			pc          <= i_redirect.target;
			fetch_valid <= 1'b0;  // word read at the old pc is dropped
		end
		else
		begin
			pc          <= pc + imem_addr_t'(1);
			fetch_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		fetch_pc <= pc;  // tracks the registered memory read
	end

	always_comb
	begin
		o_fetch.word  = fetch_valid ? i_read_data : nop_word;  // bubble reads as nop
		o_fetch.pc    = fetch_pc;
		o_fetch.valid = fetch_valid;
	end

endmodule

`default_nettype wire

// ==== design/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import pat_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  fetch_t     i_fetch,
	input  redirect_t  i_redirect,
	output dmem_addr_t o_dmem_addr,
	input  data_t      i_dmem_data,
	output decoded_t   o_decoded
);

	instr_t   word;
	data_t    imm;        // i8 immediate / address
	data_t    shift_amt;  // i3 amount zero extended
	logic     is_i8;
	logic     is_i3;
	decoded_t next;

	assign word      = i_fetch.word;
	assign imm       = word[data_width-1:0];
	assign shift_amt = data_t'(word[shift_width-1:0]);

	// i8 unless escaped, i3 unless escaped twice, else i0
	assign is_i8 = (word[11:8] != prefix_code);
	assign is_i3 = !is_i8 && (word[7:4] != prefix_code);

	assign o_dmem_addr = word[dmem_addr_width-1:0];  // operand read this cycle

	// ========================================================================
	// opcode classification
	// ========================================================================
	always_comb
	begin
		next               = '0;  // unknown and dropped ops write nothing
		next.valid         = i_fetch.valid && !i_redirect.taken;  // squash behind branch
		next.cond          = cond_e'(word[14:13]);
		next.operand_b     = imm;
		next.mem_addr      = word[dmem_addr_width-1:0];
		next.branch_offset = imm;
		next.pc            = i_fetch.pc;
		if (is_i8)
		begin
			case (op8_e'(word[11:8]))
				op8_or,
				op8_and,
				op8_add,
				op8_sub,
				op8_ldi:
				begin
					next.writes_acc = 1'b1;  // immediate operand
					case (op8_e'(word[11:8]))
						op8_or:   next.alu_op = alu_or;
						op8_and:  next.alu_op = alu_and;
						op8_add:  next.alu_op = alu_add;
						op8_sub:  next.alu_op = alu_sub;
						default:  next.alu_op = alu_pass_b;  // ldi
					endcase
				end
				op8_orm,
				op8_andm,
				op8_addm,
				op8_subm,
				op8_ldm:
				begin
					next.operand_b  = i_dmem_data;  // memory operand
					next.writes_acc = 1'b1;
					case (op8_e'(word[11:8]))
						op8_orm:  next.alu_op = alu_or;
						op8_andm: next.alu_op = alu_and;
						op8_addm: next.alu_op = alu_add;
						op8_subm: next.alu_op = alu_sub;
						default:  next.alu_op = alu_pass_b;  // ldm
					endcase
				end
				op8_bf:   next.is_branch = 1'b1;
				op8_bb:
				begin
					next.is_branch   = 1'b1;
					next.branch_back = 1'b1;
				end
				op8_stm:  next.writes_mem = 1'b1;
				default:  ;  // call, setsp
			endcase
		end
		else if (is_i3)
		begin
			next.operand_b = shift_amt;
			case (op3_e'(word[7:4]))
				op3_shl,
				op3_shlo,
				op3_shr,
				op3_asr:
				begin
					next.writes_acc = 1'b1;
					case (op3_e'(word[7:4]))
						op3_shl:  next.alu_op = alu_shl;
						op3_shlo: next.alu_op = alu_shlo;
						op3_shr:  next.alu_op = alu_shr;
						default:  next.alu_op = alu_asr;
					endcase
				end
				op3_in:
				begin
					next.is_in      = 1'b1;  // acc from the input port
					next.writes_acc = 1'b1;
				end
				op3_out:  next.is_out = 1'b1;
				default:  ;  // setb, incsp, decsp
			endcase
		end
		else
		begin
			case (op0_e'(word[3:0]))
				op0_not:
				begin
					next.alu_op     = alu_not;
					next.writes_acc = 1'b1;
				end
				op0_test: next.is_test = 1'b1;
				default:  ;  // nop, mov, return, stack ops
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		o_decoded <= next;
		if (reset)
			o_decoded.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import pat_pkg::*;
(
	input  alu_op_e i_op,
	input  data_t   i_a,   // accumulator
	input  data_t   i_b,   // operand
	output data_t   o_y
);

	logic [shift_width-1:0] amt;
	data_t                  fill;  // ones shifted in by shlo

	assign amt  = i_b[shift_width-1:0];
	assign fill = ~(data_t'('1) << amt);

	always_comb
	begin
		case (i_op)
			alu_or:     o_y = i_a | i_b;
			alu_and:    o_y = i_a & i_b;
			alu_not:    o_y = ~i_a;
			alu_add:    o_y = i_a + i_b;  // wraps mod 256
			alu_sub:    o_y = i_a - i_b;
			alu_shl:    o_y = i_a << amt;
			alu_shlo:   o_y = (i_a << amt) | fill;
			alu_shr:    o_y = i_a >> amt;
			alu_asr:    o_y = data_t'($signed(i_a) >>> amt);  // sign fills
			alu_pass_b: o_y = i_b;  // ldi / ldm
			default:    o_y = i_b;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory import pat_pkg::*;
(
	input  wire        clk,
	input  dmem_addr_t i_read_addr,
	output data_t      o_read_data,
	input  logic       i_write,
	input  dmem_addr_t i_write_addr,
	input  data_t      i_write_data
);

	data_t mem [0:(1 << dmem_addr_width)-1];

	assign o_read_data = mem[i_read_addr];  // async, decoder sees it same cycle

	always_ff @(posedge clk)
	begin
		if (i_write)
			mem[i_write_addr] <= i_write_data;  // lands at the end of execute
	end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import pat_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  decoded_t   i_decoded,
	input  data_t      i_inputs,
	output redirect_t  o_redirect,
	output logic       o_dmem_write,
	output dmem_addr_t o_dmem_addr,
	output data_t      o_dmem_data,
	output data_t      o_outputs,
	output logic       o_out_valid
);

	data_t      acc;        // the accumulator
	logic       z_flag;
	logic       n_flag;
	logic       cond_true;
	logic       commit;     // valid and predicate holds
	data_t      alu_y;
	imem_addr_t offset;

	alu u_alu
	(
		.i_op (i_decoded.alu_op),
		.i_a  (acc),
		.i_b  (i_decoded.operand_b),
		.o_y  (alu_y)
	);

	// ========================================================================
	// predicate
	// ========================================================================
	always_comb
	begin
		case (i_decoded.cond)
			cond_zero: cond_true = z_flag;
			cond_neg:  cond_true = n_flag;
			default:   cond_true = 1'b1;  // always, and code 3
		endcase
	end

	assign commit = i_decoded.valid && cond_true;

	// branch target relative to the branch's own address
	assign offset            = imem_addr_t'(i_decoded.branch_offset);
	assign o_redirect.taken  = commit && i_decoded.is_branch;
	assign o_redirect.target = i_decoded.branch_back ? i_decoded.pc - offset
		: i_decoded.pc + offset;

	assign o_dmem_write = commit && i_decoded.writes_mem;  // stm
	assign o_dmem_addr  = i_decoded.mem_addr;
	assign o_dmem_data  = acc;

	// ========================================================================
	// architectural state
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc         <= '0;
			z_flag      <= 1'b0;
			n_flag      <= 1'b0;
			o_outputs   <= '0;
			o_out_valid <= 1'b0;
		end
		else
		begin
			o_out_valid <= commit && i_decoded.is_out;  // one-cycle strobe
			if (commit && i_decoded.writes_acc)
				acc <= i_decoded.is_in ? i_inputs : alu_y;
			if (commit && i_decoded.is_test)
			begin
				z_flag <= (acc == '0);
				n_flag <= acc[data_width-1];
			end
			if (commit && i_decoded.is_out)
				o_outputs <= acc;  // held until next out
		end
	end

endmodule

`default_nettype wire

// ==== design/pat_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_core import pat_pkg::*;
(
	input  wire        clk,
	input  wire        reset,
	input  logic       i_imem_write,
	input  imem_addr_t i_imem_addr,
	input  instr_t     i_imem_data,
	input  data_t      i_inputs,
	output data_t      o_outputs,
	output logic       o_out_valid
);

	imem_addr_t imem_read_addr;
	instr_t     imem_read_data;
	fetch_t     fetch;
	decoded_t   decoded;
	redirect_t  redirect;     // execute -> fetch and decoder
	dmem_addr_t dmem_read_addr;
	data_t      dmem_read_data;
	logic       dmem_write;
	dmem_addr_t dmem_write_addr;
	data_t      dmem_write_data;

	// ========================================================================
	// fetch -> decode -> execute
	// ========================================================================
	instruction_memory u_imem
	(
		.clk          (clk),
		.i_write      (i_imem_write),
		.i_write_addr (i_imem_addr),
		.i_write_data (i_imem_data),
		.i_read_addr  (imem_read_addr),
		.o_read_data  (imem_read_data)
	);

	fetch_unit u_fetch
	(
		.clk         (clk),
		.reset       (reset),
		.i_redirect  (redirect),
		.o_read_addr (imem_read_addr),
		.i_read_data (imem_read_data),
		.o_fetch     (fetch)
	);

	decoder u_decoder
	(
		.clk         (clk),
		.reset       (reset),
		.i_fetch     (fetch),
		.i_redirect  (redirect),
		.o_dmem_addr (dmem_read_addr),
		.i_dmem_data (dmem_read_data),
		.o_decoded   (decoded)
	);

	data_memory u_dmem
	(
		.clk          (clk),
		.i_read_addr  (dmem_read_addr),   // decoder reads
		.o_read_data  (dmem_read_data),
		.i_write      (dmem_write),       // execute writes
		.i_write_addr (dmem_write_addr),
		.i_write_data (dmem_write_data)
	);

	execute_stage u_execute
	(
		.clk          (clk),
		.reset        (reset),
		.i_decoded    (decoded),
		.i_inputs     (i_inputs),
		.o_redirect   (redirect),
		.o_dmem_write (dmem_write),
		.o_dmem_addr  (dmem_write_addr),
		.o_dmem_data  (dmem_write_data),
		.o_outputs    (o_outputs),
		.o_out_valid  (o_out_valid)
	);

endmodule

`default_nettype wire

// ==== testbench/pat_model.svh ====
`ifndef PAT_MODEL_SVH
`define PAT_MODEL_SVH

typedef instr_t instr_q_t[$];  // program image, index is the word address
typedef data_t  data_q_t[$];   // out values in commit order

// ============================================================================
// instruction encoders
// ============================================================================
// pointer bits 19-15 and field_op bit 12 left at zero
function automatic instr_t enc_i8(logic [1:0] cond, logic [3:0] op, data_t imm);
	return {5'b0, cond, 1'b0, op, imm};
endfunction

function automatic instr_t enc_i3(logic [1:0] cond, logic [3:0] op, logic [2:0] amt);
	return {5'b0, cond, 1'b0, prefix_code, op, 1'b0, amt};  // bit 3 unused
endfunction

function automatic instr_t enc_i0(logic [1:0] cond, logic [3:0] op);
	return {5'b0, cond, 1'b0, prefix_code, prefix_code, op};
endfunction

// ============================================================================
// reference interpreter
// ============================================================================
// one instruction per step, no pipeline; stops on max_outs outputs
// or on a taken branch to its own address
function automatic data_q_t run_model(instr_q_t prog, data_t in_val, int max_outs);
	data_q_t    outs;
	data_t      mem [0:255];
	data_t      acc;
	logic       z;
	logic       n;
	logic       holds;
	instr_t     w;
	data_t      imm;
	logic [2:0] amt;
	int         pc;
	int         off;
	int         target;
	int         steps;
	acc = '0;
	z   = 1'b0;
	n   = 1'b0;
	pc  = 0;
	for (int i = 0; i < 256; i++)
	begin
		mem[i] = '0;
	end
	for (steps = 0; steps < 20000 && outs.size() < max_outs; steps++)
	begin
		w   = (pc < prog.size()) ? prog[pc] : nop_word;  // unloaded words never reached
		imm = w[7:0];
		amt = w[2:0];
		off = imm;  // unsigned branch distance
		case (w[14:13])
			2'd1:    holds = z;
			2'd2:    holds = n;
			default: holds = 1'b1;
		endcase
		if (!holds)
		begin
			pc = (pc + 1) % 1024;  // predicated off, falls through
			continue;
		end
		if (w[11:8] == op8_bf || w[11:8] == op8_bb)
		begin
			target = (w[11:8] == op8_bf) ? pc + off : pc - off;
			target = (target + 1024) % 1024;  // program space wraps
			if (target == pc)
				break;  // end-of-program loop
			pc = target;
			continue;
		end
		case (w[11:8])
			op8_or:   acc = acc | imm;
			op8_and:  acc = acc & imm;
			op8_add:  acc = acc + imm;
			op8_sub:  acc = acc - imm;
			op8_ldi:  acc = imm;
			op8_ldm:  acc = mem[imm];
			op8_orm:  acc = acc | mem[imm];
			op8_andm: acc = acc & mem[imm];
			op8_addm: acc = acc + mem[imm];
			op8_subm: acc = acc - mem[imm];
			op8_stm:  mem[imm] = acc;
			prefix_code:
			begin
				case (w[7:4])
					op3_shl:  acc = acc << amt;
					op3_shlo: acc = (acc << amt) | data_t'((9'd1 << amt) - 9'd1);
					op3_shr:  acc = acc >> amt;
					op3_asr:
					begin
						repeat (amt)
							acc = {acc[7], acc[7:1]};  // one bit at a time, sign kept
					end
					op3_in:   acc = in_val;
					op3_out:  outs.push_back(acc);
					prefix_code:
					begin
						case (w[3:0])
							op0_not:  acc = ~acc;
							op0_test:
							begin
								z = (acc == 8'h00);
								n = acc[7];
							end
							default:  ;  // nop and everything dropped
						endcase
					end
					default:  ;
				endcase
			end
			default:  ;  // call, setsp and other dropped i8 ops
		endcase
		pc = (pc + 1) % 1024;
	end
	return outs;
endfunction

`endif

// ==== testbench/tb_pat.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pat import pat_pkg::*;
();

	localparam int reset_cycles = 16;
	localparam int out_timeout  = 2000;  // cycles allowed for one program's outs
	localparam int drain_cycles = 40;    // idle window that catches stray outs

	logic       clk;
	logic       reset;
	logic       imem_write;
	imem_addr_t imem_addr;
	instr_t     imem_data;
	data_t      inputs;
	data_t      outputs;
	logic       out_valid;

	`include "pat_model.svh"

	instr_q_t prog_q;       // program under construction
	data_q_t  expected_q;   // model outs not yet seen
	int       out_seen;
	int       error_count;
	int       check_count;

	pat_core i_dut
	(
		.clk          (clk),
		.reset        (reset),
		.i_imem_write (imem_write),
		.i_imem_addr  (imem_addr),
		.i_imem_data  (imem_data),
		.i_inputs     (inputs),
		.o_outputs    (outputs),
		.o_out_valid  (out_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;  // 4 ns period
	end

	// ========================================================================
	// checking
	// ========================================================================
	task automatic check_value(input string what, input data_t got, input data_t exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("ERROR %0t ns: %s got %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	// outputs move on posedge and are sampled half a cycle later
	always @(negedge clk)
	begin
		if (out_valid === 1'b1)
		begin
			out_seen++;
			if (expected_q.size() == 0)
			begin
				error_count++;
				$display("unexpected out pulse carrying %02h at %0t ns", outputs, $time);
			end
			else
				check_value($sformatf("out #%0d", out_seen), outputs, expected_q.pop_front());
		end
	end

	// ========================================================================
	// program building and running
	// ========================================================================
	function automatic void emit(instr_t w);
		prog_q.push_back(w);
	endfunction

	function automatic void op_out(instr_t w);
		emit(w);
		emit(enc_i3(cond_always, op3_out, 3'd0));
	endfunction

	function automatic void load_op_out(data_t a, instr_t w);
		emit(enc_i8(cond_always, op8_ldi, a));
		op_out(w);
	endfunction

	task automatic run_program(input string name, input data_t in_val);
		int cycles;
		int n;
		emit(enc_i8(cond_always, op8_bf, 8'h00));  // park on bf to self
		emit(nop_word);                             // shadow words stay defined
		emit(nop_word);
		expected_q = run_model(prog_q, in_val, 64);
		n          = expected_q.size();
		out_seen   = 0;
		@(negedge clk);
		reset  = 1'b1;
		inputs = in_val;
		foreach (prog_q[i])
		begin
			@(negedge clk);
			imem_write = 1'b1;
			imem_addr  = imem_addr_t'(i);
			imem_data  = prog_q[i];
		end
		@(negedge clk);
		imem_write = 1'b0;
		repeat (reset_cycles - 1)
			@(negedge clk);
		reset  = 1'b0;
		cycles = 0;
		while (out_seen < n && cycles < out_timeout)
		begin
			@(negedge clk);
			cycles++;
		end
		if (out_seen < n)
		begin
			error_count++;
			$display("timeout in %s: only %0d of %0d outputs arrived", name, out_seen, n);
		end
		repeat (drain_cycles)
			@(negedge clk);  // squashed outs would show up here
		$display("%s: %0d outputs expected, %0d seen", name, n, out_seen);
		prog_q.delete();
	endtask

	// ========================================================================
	// tests
	// ========================================================================
	task automatic test_alu();
		data_t a;
		data_t b;
		for (int r = 0; r < 3; r++)
		begin
			a = data_t'($urandom);
			b = data_t'($urandom);
			if (r == 0)
			begin
				a[7] = 1'b1;  // negative start so asr must fill with ones
				b[0] = 1'b1;  // odd amount so the shifts never skip the fill
			end
			load_op_out(a, enc_i8(cond_always, op8_or, b));
			load_op_out(a, enc_i8(cond_always, op8_and, b));
			load_op_out(a, enc_i8(cond_always, op8_add, b));
			load_op_out(a, enc_i8(cond_always, op8_sub, b));
			load_op_out(a, enc_i3(cond_always, op3_shl, b[2:0]));
			load_op_out(a, enc_i3(cond_always, op3_shlo, b[2:0]));
			load_op_out(a, enc_i3(cond_always, op3_shr, b[2:0]));
			load_op_out(a, enc_i3(cond_always, op3_asr, b[2:0]));
			load_op_out(a, enc_i0(cond_always, op0_not));
		end
		run_program("alu", data_t'($urandom));
	endtask

	task automatic test_memory();
		data_t addr [4];
		for (int i = 0; i < 4; i++)
		begin
			addr[i] = data_t'($urandom);
			emit(enc_i8(cond_always, op8_ldi, data_t'($urandom)));
			emit(enc_i8(cond_always, op8_stm, addr[i]));
		end
		emit(nop_word);  // last store lands before the first load decodes
		for (int i = 0; i < 4; i++)
		begin
			op_out(enc_i8(cond_always, op8_ldm, addr[i]));
			op_out(enc_i8(cond_always, op8_addm, addr[(i + 1) % 4]));
			op_out(enc_i8(cond_always, op8_subm, addr[(i + 2) % 4]));
			op_out(enc_i8(cond_always, op8_orm, addr[(i + 3) % 4]));
			op_out(enc_i8(cond_always, op8_andm, addr[i]));
		end
		run_program("memory", data_t'($urandom));
	endtask

	task automatic test_input();
		for (int r = 0; r < 2; r++)
		begin
			load_op_out(8'h00, enc_i3(cond_always, op3_in, 3'd0));
			op_out(enc_i0(cond_always, op0_not));  // in value really reached acc
			run_program("input port", data_t'($urandom));
		end
	endtask

	task automatic test_predication();
		data_t vals [3];
		vals[0] = 8'h00;
		vals[1] = data_t'($urandom) | 8'h80;           // negative
		vals[2] = (data_t'($urandom) & 8'h7f) | 8'h01;  // positive and nonzero
		foreach (vals[i])
		begin
			emit(enc_i8(cond_always, op8_ldi, vals[i]));
			emit(enc_i0(cond_always, op0_test));
			load_op_out(vals[i], enc_i8(cond_zero, op8_ldi, 8'h11));
			emit(enc_i0(cond_always, op0_test));
			load_op_out(vals[i], enc_i8(cond_neg, op8_ldi, 8'h22));
			emit(enc_i0(cond_always, op0_test));
			emit(enc_i3(cond_zero, op3_out, 3'd0));  // out only if its predicate holds
			emit(enc_i3(cond_neg, op3_out, 3'd0));
			op_out(enc_i8(2'd3, op8_ldi, 8'h33));  // code 3 acts as always
		end
		run_program("predication", data_t'($urandom));
	endtask

	task automatic test_branches();
		data_t count;
		count = data_t'(($urandom % 4) + 2);
		emit(enc_i8(cond_always, op8_ldi, 8'h5a));    // 0
		emit(enc_i3(cond_always, op3_out, 3'd0));     // 1
		emit(enc_i8(cond_always, op8_bf, 8'd3));      // 2  jump to 5
		emit(enc_i8(cond_always, op8_ldi, 8'hee));    // 3  squashed
		emit(enc_i3(cond_always, op3_out, 3'd0));     // 4  squashed
		emit(enc_i8(cond_always, op8_ldi, count));    // 5
		emit(enc_i3(cond_always, op3_out, 3'd0));     // 6
		emit(enc_i8(cond_always, op8_sub, 8'd1));     // 7  loop head
		emit(enc_i0(cond_always, op0_test));          // 8
		emit(enc_i3(cond_always, op3_out, 3'd0));     // 9
		emit(enc_i8(cond_zero, op8_bf, 8'd3));        // 10 exit to 13 at zero
		emit(enc_i8(cond_always, op8_bb, 8'd4));      // 11 back to 7
		emit(enc_i3(cond_always, op3_out, 3'd0));     // 12 shadow of both branches
		emit(enc_i8(cond_always, op8_ldi, 8'h77));    // 13
		emit(enc_i3(cond_always, op3_out, 3'd0));     // 14
		run_program("branches", data_t'($urandom));
	endtask

	task automatic test_dropped();
		data_t  r;
		instr_t mov;
		r   = data_t'($urandom);
		mov = enc_i0(cond_always, 4'h1);
		mov[19:15] = 5'h15;  // field pointers are ignored
		mov[12]    = 1'b1;   // field_op is ignored
		load_op_out(r, enc_i8(cond_always, 4'ha, data_t'($urandom)));  // call
		op_out(enc_i8(cond_always, 4'hc, data_t'($urandom)));          // setsp
		op_out(mov);
		run_program("dropped opcodes", data_t'($urandom));
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================
	initial
	begin
		error_count = 0;
		check_count = 0;
		out_seen    = 0;
		reset       = 1'b1;
		imem_write  = 1'b0;
		imem_addr   = '0;
		imem_data   = '0;
		inputs      = '0;
		void'($urandom(32'h0c4bd4cb));
		test_alu();
		test_memory();
		test_input();
		test_predication();
		test_branches();
		test_dropped();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+testbench
design/pat_pkg.sv
design/instruction_memory.sv
design/fetch_unit.sv
design/decoder.sv
design/alu.sv
design/data_memory.sv
design/execute_stage.sv
design/pat_core.sv
testbench/tb_pat.sv
